//--- hw/loopFilter_defs.svh
// ----------------------------------------------------------
// Carrier loop filter widths
// Error, limit, accumulator, gain code and NCO word sizes
// ----------------------------------------------------------
`ifndef LOOP_FILTER_DEFS_SVH
`define LOOP_FILTER_DEFS_SVH

// Phase and frequency detector samples
`define LF_ERROR_WIDTH 12

// Programmable integrator limits, compared with the integer part
`define LF_LIMIT_WIDTH 32

// Lag accumulator and loop output
`define LF_ACCUM_WIDTH 40
`define LF_FRACTION_BITS 8

`define LF_EXP_WIDTH 5
`define LF_NCO_WIDTH 32

`endif

//--- hw/loopGainPkg.sv
// ----------------------------------------------------------
// Numeric types of the carrier loop filter
// Samples, accumulator words, limits and NCO words
// ----------------------------------------------------------
`include "loopFilter_defs.svh"

package loopGainPkg;

    typedef logic signed [`LF_ERROR_WIDTH-1:0] errorSample;
    typedef logic signed [`LF_ACCUM_WIDTH-1:0] accumWord;
    typedef logic signed [`LF_LIMIT_WIDTH-1:0] limitWord;
    typedef logic        [`LF_NCO_WIDTH-1:0]   phaseWord;

    // Gain code that leaves the error unscaled
    localparam int unityCode = 3;

    // Code 0 mutes the error, codes below unity shift right with floor rounding
    function automatic accumWord scaleError(input errorSample err,
                                            input logic [`LF_EXP_WIDTH-1:0] code);
        accumWord wide;
        wide = accumWord'(err);
        if (code == '0) begin
            return '0;
        end
        if (code < unityCode) begin
            return wide >>> (unityCode - code);
        end
        return wide <<< (code - unityCode);
    endfunction

endpackage

//--- hw/loopControlPkg.sv
// ----------------------------------------------------------
// Control types of the carrier loop filter
// Gain exponent codes and the acquisition mode
// ----------------------------------------------------------
`include "loopFilter_defs.svh"

package loopControlPkg;

    // Power of two gain code, see loopGainPkg::scaleError
    typedef logic [`LF_EXP_WIDTH-1:0] gainExp;

    // Frequency pull until acquired, then phase tracking
    typedef enum logic {
        freqPull   = 1'b0,
        phaseTrack = 1'b1
    } loopMode;

    function automatic loopMode decodeMode(input logic freqAcquired);
        if (freqAcquired) begin
            return phaseTrack;
        end
        return freqPull;
    endfunction

endpackage

//--- hw/loopConfigIf.sv
// ----------------------------------------------------------
// Loop filter configuration bundle
// Gain codes, integrator limits and mode for both gain paths
// ----------------------------------------------------------
`timescale 1ns/1ps

interface loopConfigIf;

    loopControlPkg::gainExp  phaseLagExp;
    loopControlPkg::gainExp  freqLagExp;
    loopControlPkg::gainExp  leadExp;
    loopGainPkg::limitWord   upperLimit;
    loopGainPkg::limitWord   lowerLimit;
    loopControlPkg::loopMode mode;

    // Driven from the top level ports
    modport source (
        output phaseLagExp,
        output freqLagExp,
        output leadExp,
        output upperLimit,
        output lowerLimit,
        output mode
    );

    // Integral path needs its own gains and the limits
    modport lag (
        input phaseLagExp,
        input freqLagExp,
        input upperLimit,
        input lowerLimit,
        input mode
    );

    modport lead (
        input leadExp,
        input mode
    );

endinterface

//--- hw/lagGain.sv
// ----------------------------------------------------------
// Lag (integral) path of the carrier loop filter
// Scaled error selection into a saturating accumulator
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "loopFilter_defs.svh"

module lagGain (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clkEn,
    input  loopGainPkg::errorSample phaseError,
    input  loopGainPkg::errorSample freqError,
    input  logic                    clearAccum,
    loopConfigIf.lag                cfg,
    output loopGainPkg::accumWord   lagAccum,
    output loopGainPkg::accumWord   lagNext
);

    loopGainPkg::accumWord phaseLagError;
    loopGainPkg::accumWord freqLagError;
    loopGainPkg::accumWord lagError;
    loopGainPkg::accumWord sum;
    loopGainPkg::limitWord sumTop;
    loopGainPkg::accumWord upperClamp;
    loopGainPkg::accumWord lowerClamp;
    loopGainPkg::accumWord satValue;
    logic                  limitsInverted;

    // Stage E, both errors scaled by their own exponents
    always_ff @(posedge clk) begin
        if (reset) begin
            phaseLagError <= '0;
            freqLagError  <= '0;
        end else if (clkEn) begin
            phaseLagError <= loopGainPkg::scaleError(phaseError, cfg.phaseLagExp);
            freqLagError  <= loopGainPkg::scaleError(freqError, cfg.freqLagExp);
        end
    end

    // Stage E+1, mode picks the error to integrate
    always_ff @(posedge clk) begin
        if (reset) begin
            lagError <= '0;
        end else if (clkEn) begin
            if (cfg.mode == loopControlPkg::freqPull) begin
                lagError <= freqLagError;
            end else begin
                lagError <= phaseLagError;
            end
        end
    end

    // Integer part of the candidate sum is what the limits see
    assign sum    = lagAccum + lagError;
    assign sumTop = sum[`LF_ACCUM_WIDTH-1:`LF_FRACTION_BITS];

    // Clamp values pad the limit with zero or one fraction bits
    assign upperClamp = {cfg.upperLimit, {`LF_FRACTION_BITS{1'b0}}};
    assign lowerClamp = {cfg.lowerLimit, {`LF_FRACTION_BITS{1'b1}}};

    // Negative upper with non-negative lower is not a usable window
    assign limitsInverted = cfg.upperLimit[`LF_LIMIT_WIDTH-1]
                            && !cfg.lowerLimit[`LF_LIMIT_WIDTH-1];

    // Test the limit on the side the sum leans toward first
    always_comb begin
        if (limitsInverted) begin
            satValue = lagAccum;
        end else if (sum[`LF_ACCUM_WIDTH-1]) begin
            if (sumTop <= cfg.lowerLimit) begin
                satValue = lowerClamp;
            end else if (sumTop >= cfg.upperLimit) begin
                satValue = upperClamp;
            end else begin
                satValue = sum;
            end
        end else begin
            if (sumTop >= cfg.upperLimit) begin
                satValue = upperClamp;
            end else if (sumTop <= cfg.lowerLimit) begin
                satValue = lowerClamp;
            end else begin
                satValue = sum;
            end
        end
    end

    // Next accumulator value, also used by the NCO for the loop output
    // Clear acts on any edge, the enable only gates the integration
    always_comb begin
        if (clearAccum) begin
            lagNext = '0;
        end else if (clkEn) begin
            lagNext = satValue;
        end else begin
            lagNext = lagAccum;
        end
    end

    // Stage E+2
    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum <= '0;
        end else begin
            lagAccum <= lagNext;
        end
    end

endmodule

//--- hw/leadGain.sv
// ----------------------------------------------------------
// Lead (proportional) path of the carrier loop filter
// ----------------------------------------------------------
`timescale 1ns/1ps

module leadGain (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clkEn,
    input  loopGainPkg::errorSample phaseError,
    input  loopGainPkg::errorSample freqError,
    loopConfigIf.lead               cfg,
    output loopGainPkg::accumWord   leadError
);

    loopGainPkg::accumWord phaseLeadError;
    loopGainPkg::accumWord freqLeadError;

    // Stage E, one exponent serves both errors
    always_ff @(posedge clk) begin
        if (reset) begin
            phaseLeadError <= '0;
            freqLeadError  <= '0;
        end else if (clkEn) begin
            phaseLeadError <= loopGainPkg::scaleError(phaseError, cfg.leadExp);
            freqLeadError  <= loopGainPkg::scaleError(freqError, cfg.leadExp);
        end
    end

    // Stage E+1, same selection point as the lag path so the
    // proportional term lines up with the integrator update
    always_ff @(posedge clk) begin
        if (reset) begin
            leadError <= '0;
        end else if (clkEn) begin
            if (cfg.mode == loopControlPkg::freqPull) begin
                leadError <= freqLeadError;
            end else begin
                leadError <= phaseLeadError;
            end
        end
    end

endmodule

//--- hw/carrierNco.sv
// ----------------------------------------------------------
// Carrier NCO
// Loop output sum and the 32-bit phase accumulator it steers
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "loopFilter_defs.svh"

module carrierNco (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clkEn,
    input  loopGainPkg::accumWord leadError,
    input  loopGainPkg::accumWord lagNext,
    input  loopGainPkg::phaseWord centerFreq,
    output loopGainPkg::accumWord loopOut,
    output loopGainPkg::phaseWord ncoPhase
);

    loopGainPkg::phaseWord freqWord;

    // Stage E+2, lead term plus the accumulator value loaded on this edge
    always_ff @(posedge clk) begin
        if (reset) begin
            loopOut <= '0;
        end else if (clkEn) begin
            loopOut <= leadError + lagNext;
        end
    end

    // Integer part of the loop output trims the center frequency
    assign freqWord = centerFreq + loopOut[`LF_ACCUM_WIDTH-1:`LF_FRACTION_BITS];

    // Stage E+3, phase wraps modulo the word size
    always_ff @(posedge clk) begin
        if (reset) begin
            ncoPhase <= '0;
        end else if (clkEn) begin
            ncoPhase <= ncoPhase + freqWord;
        end
    end

endmodule

//--- hw/carrierLoopFilter.sv
// ----------------------------------------------------------
// Carrier tracking loop filter top level
// Second-order lead/lag filter steering the carrier NCO
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "loopFilter_defs.svh"

module carrierLoopFilter (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clkEn,
    input  logic                              clearAccum,
    input  logic                              freqAcquired,
    input  logic signed [`LF_ERROR_WIDTH-1:0] phaseError,
    input  logic signed [`LF_ERROR_WIDTH-1:0] freqError,
    input  logic        [`LF_EXP_WIDTH-1:0]   phaseLagExp,
    input  logic        [`LF_EXP_WIDTH-1:0]   freqLagExp,
    input  logic        [`LF_EXP_WIDTH-1:0]   leadExp,
    input  logic signed [`LF_LIMIT_WIDTH-1:0] upperLimit,
    input  logic signed [`LF_LIMIT_WIDTH-1:0] lowerLimit,
    input  logic        [`LF_NCO_WIDTH-1:0]   centerFreq,
    output logic signed [`LF_ACCUM_WIDTH-1:0] lagAccum,
    output logic signed [`LF_ACCUM_WIDTH-1:0] loopOut,
    output logic        [`LF_NCO_WIDTH-1:0]   ncoPhase
);

    loopGainPkg::accumWord leadError;
    loopGainPkg::accumWord lagNext;

    loopConfigIf loopCfg ();

    // Configuration onto the shared bundle
    assign loopCfg.phaseLagExp = phaseLagExp;
    assign loopCfg.freqLagExp  = freqLagExp;
    assign loopCfg.leadExp     = leadExp;
    assign loopCfg.upperLimit  = upperLimit;
    assign loopCfg.lowerLimit  = lowerLimit;
    assign loopCfg.mode        = loopControlPkg::decodeMode(freqAcquired);

    lagGain lagPath (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .phaseError (phaseError),
        .freqError  (freqError),
        .clearAccum (clearAccum),
        .cfg        (loopCfg.lag),
        .lagAccum   (lagAccum),
        .lagNext    (lagNext)
    );

    leadGain leadPath (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .phaseError (phaseError),
        .freqError  (freqError),
        .cfg        (loopCfg.lead),
        .leadError  (leadError)
    );

    // Loop output and phase accumulator
    carrierNco nco (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .leadError  (leadError),
        .lagNext    (lagNext),
        .centerFreq (centerFreq),
        .loopOut    (loopOut),
        .ncoPhase   (ncoPhase)
    );

endmodule

//--- testbench/carrierLoopFilterTb.sv
// ----------------------------------------------------------
// Testbench for the carrier tracking loop filter
// LFSR stimulus against a cycle model of the lead/lag stages
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "loopFilter_defs.svh"

module carrierLoopFilterTb;

    localparam int runLimit = 5000;

    logic                              clk;
    logic                              reset;
    logic                              clkEn;
    logic                              clearAccum;
    logic                              freqAcquired;
    logic signed [`LF_ERROR_WIDTH-1:0] phaseError;
    logic signed [`LF_ERROR_WIDTH-1:0] freqError;
    logic        [`LF_EXP_WIDTH-1:0]   phaseLagExp;
    logic        [`LF_EXP_WIDTH-1:0]   freqLagExp;
    logic        [`LF_EXP_WIDTH-1:0]   leadExp;
    logic signed [`LF_LIMIT_WIDTH-1:0] upperLimit;
    logic signed [`LF_LIMIT_WIDTH-1:0] lowerLimit;
    logic        [`LF_NCO_WIDTH-1:0]   centerFreq;
    logic signed [`LF_ACCUM_WIDTH-1:0] lagAccum;
    logic signed [`LF_ACCUM_WIDTH-1:0] loopOut;
    logic        [`LF_NCO_WIDTH-1:0]   ncoPhase;

    // Model state with one register per DUT stage
    logic signed [`LF_ACCUM_WIDTH-1:0] mPhaseLag;
    logic signed [`LF_ACCUM_WIDTH-1:0] mFreqLag;
    logic signed [`LF_ACCUM_WIDTH-1:0] mPhaseLead;
    logic signed [`LF_ACCUM_WIDTH-1:0] mFreqLead;
    logic signed [`LF_ACCUM_WIDTH-1:0] mLagError;
    logic signed [`LF_ACCUM_WIDTH-1:0] mLeadError;
    logic signed [`LF_ACCUM_WIDTH-1:0] mLagAccum;
    logic signed [`LF_ACCUM_WIDTH-1:0] mLoopOut;
    logic        [`LF_NCO_WIDTH-1:0]   mPhase;

    logic [31:0] lfsrState;
    string       testName;
    logic        checking;
    int          checkCount;
    int          valueErrors;
    int          timeoutErrors;

    carrierLoopFilter dut (
        .clk          (clk),
        .reset        (reset),
        .clkEn        (clkEn),
        .clearAccum   (clearAccum),
        .freqAcquired (freqAcquired),
        .phaseError   (phaseError),
        .freqError    (freqError),
        .phaseLagExp  (phaseLagExp),
        .freqLagExp   (freqLagExp),
        .leadExp      (leadExp),
        .upperLimit   (upperLimit),
        .lowerLimit   (lowerLimit),
        .centerFreq   (centerFreq),
        .lagAccum     (lagAccum),
        .loopOut      (loopOut),
        .ncoPhase     (ncoPhase)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // Right shifting Galois LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // Error times 2**(code-3) with floor rounding for the right shifts
    function automatic logic signed [39:0] scaleRef(input logic signed [11:0] err,
                                                    input logic [4:0] code);
        longint value;
        longint divisor;
        value = err;
        if (code == 0) begin
            return 0;
        end
        if (code >= 3) begin
            return value * (longint'(1) << (code - 3));
        end
        divisor = (code == 1) ? 4 : 2;
        if (value < 0) begin
            return (value - divisor + 1) / divisor;
        end
        return value / divisor;
    endfunction

    // Next lag accumulator with the limit tests in sum-sign order
    function automatic logic signed [39:0] saturateRef(input logic signed [39:0] accum,
                                                       input logic signed [39:0] step,
                                                       input logic signed [31:0] upper,
                                                       input logic signed [31:0] lower);
        logic signed [39:0] sum;
        logic signed [31:0] top;
        longint             upperClamp;
        longint             lowerClamp;
        sum = accum + step;
        top = sum[39:8];
        upperClamp = longint'(upper) * 256;
        lowerClamp = longint'(lower) * 256 + 255;
        if (upper < 0 && lower >= 0) begin
            return accum;
        end
        if (sum < 0) begin
            if (top <= lower) begin
                return lowerClamp;
            end
            if (top >= upper) begin
                return upperClamp;
            end
        end else begin
            if (top >= upper) begin
                return upperClamp;
            end
            if (top <= lower) begin
                return lowerClamp;
            end
        end
        return sum;
    endfunction

    always @(posedge clk) begin : referenceModel
        logic signed [39:0] newLag;
        if (reset) begin
            mPhaseLag  <= '0;
            mFreqLag   <= '0;
            mPhaseLead <= '0;
            mFreqLead  <= '0;
            mLagError  <= '0;
            mLeadError <= '0;
            mLagAccum  <= '0;
            mLoopOut   <= '0;
            mPhase     <= '0;
        end else begin
            if (clearAccum) begin
                newLag = '0;
            end else if (clkEn) begin
                newLag = saturateRef(mLagAccum, mLagError, upperLimit, lowerLimit);
            end else begin
                newLag = mLagAccum;
            end
            mLagAccum <= newLag;
            if (clkEn) begin
                mPhaseLag  <= scaleRef(phaseError, phaseLagExp);
                mFreqLag   <= scaleRef(freqError, freqLagExp);
                mPhaseLead <= scaleRef(phaseError, leadExp);
                mFreqLead  <= scaleRef(freqError, leadExp);
                mLagError  <= freqAcquired ? mPhaseLag : mFreqLag;
                mLeadError <= freqAcquired ? mPhaseLead : mFreqLead;
                mLoopOut   <= mLeadError + newLag;
                mPhase     <= mPhase + centerFreq + mLoopOut[39:8];
            end
        end
    end

    task automatic checkWord(input string signalName, input logic [39:0] expected,
                             input logic [39:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            valueErrors++;
            $display("** Error [%s] %s: expected %h, actual %h",
                     testName, signalName, expected, actual);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            checkWord("lagAccum", mLagAccum, lagAccum);
            checkWord("loopOut", mLoopOut, loopOut);
            checkWord("ncoPhase", {8'h00, mPhase}, {8'h00, ncoPhase});
        end
    end

    task automatic driveRandomErrors;
        logic [31:0] bits;
        drawBits(12, bits);
        phaseError <= bits[11:0];
        drawBits(12, bits);
        freqError <= bits[11:0];
    endtask

    task automatic waitForAccum(input logic signed [39:0] target, input int maxCycles);
        int   cycles;
        logic hit;
        cycles = 0;
        hit = 1'b0;
        while (!hit && cycles < maxCycles) begin
            @(negedge clk);
            hit = (lagAccum === target);
            cycles++;
        end
        assert (hit) else begin
            timeoutErrors++;
            $display("Timeout in %s: lagAccum did not reach %h within %0d cycles",
                     testName, target, maxCycles);
        end
    endtask

    task automatic runRandomCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            driveRandomErrors();
        end
    endtask

    task automatic clearOnce;
        @(posedge clk);
        clearAccum <= 1'b1;
        @(posedge clk);
        clearAccum <= 1'b0;
    endtask

    task automatic reportCounts;
        $display("Checks: %0d, value errors: %0d, timeout errors: %0d",
                 checkCount, valueErrors, timeoutErrors);
    endtask

    task automatic idleAfterReset;
        logic [31:0] bits;
        testName = "idle";
        @(negedge clk);
        checkWord("lagAccum", 40'h0, lagAccum);
        checkWord("loopOut", 40'h0, loopOut);
        checkWord("ncoPhase", 40'h0, {8'h00, ncoPhase});
        // Live gains and an open window so any enabled stage would move
        @(posedge clk);
        phaseLagExp <= 5'd9;
        freqLagExp  <= 5'd9;
        leadExp     <= 5'd9;
        upperLimit  <= 32'sh7FFF_FFFF;
        lowerLimit  <= 32'sh8000_0000;
        repeat (10) begin
            @(posedge clk);
            driveRandomErrors();
            drawBits(32, bits);
            centerFreq <= bits;
        end
    endtask

    task automatic scaleAllCodes;
        testName = "scaling";
        @(posedge clk);
        clkEn        <= 1'b1;
        freqAcquired <= 1'b0;
        upperLimit   <= 32'sh7FFF_FFFF;
        lowerLimit   <= 32'sh8000_0000;
        for (int code = 0; code < 32; code++) begin
            @(posedge clk);
            freqLagExp <= 5'(code);
            leadExp    <= 5'(31 - code);
            clearAccum <= 1'b1;
            driveRandomErrors();
            @(posedge clk);
            clearAccum <= 1'b0;
            runRandomCycles(6);
        end
    endtask

    task automatic switchMode;
        testName = "modeSwitch";
        @(posedge clk);
        phaseLagExp <= 5'd6;
        freqLagExp  <= 5'd4;
        leadExp     <= 5'd5;
        clearOnce();
        runRandomCycles(20);
        @(posedge clk);
        freqAcquired <= 1'b1;
        runRandomCycles(20);
    endtask

    task automatic saturateBothWays;
        logic signed [39:0] frozen;
        testName = "saturation";
        @(posedge clk);
        freqAcquired <= 1'b0;
        freqLagExp   <= 5'd10;
        leadExp      <= 5'd0;
        upperLimit   <= 32'sd100;
        lowerLimit   <= -32'sd100;
        freqError    <= 12'sh7FF;
        waitForAccum(40'sd100 * 256, 50);
        @(posedge clk);
        freqError <= -12'sd2048;
        waitForAccum(-40'sd100 * 256 + 255, 50);
        // Crossed windows let the test order decide the clamp
        testName = "satOrderNegative";
        @(posedge clk);
        freqLagExp <= 5'd8;
        upperLimit <= -32'sd50;
        lowerLimit <= -32'sd20;
        runRandomCycles(100);
        testName = "satOrderPositive";
        @(posedge clk);
        upperLimit <= 32'sd30;
        lowerLimit <= 32'sd60;
        runRandomCycles(100);
        testName = "satInverted";
        @(posedge clk);
        upperLimit <= -32'sd10;
        lowerLimit <= 32'sd10;
        runRandomCycles(2);
        @(negedge clk);
        frozen = lagAccum;
        repeat (20) begin
            @(posedge clk);
            driveRandomErrors();
            @(negedge clk);
            checkWord("lagAccum", frozen, lagAccum);
        end
    endtask

    task automatic clearAndSparse;
        logic [31:0] bits;
        testName = "clearIdle";
        @(posedge clk);
        upperLimit <= 32'sh7FFF_FFFF;
        lowerLimit <= 32'sh8000_0000;
        runRandomCycles(5);
        @(posedge clk);
        clkEn      <= 1'b0;
        clearAccum <= 1'b1;
        @(posedge clk);
        clearAccum <= 1'b0;
        @(negedge clk);
        checkWord("lagAccum", 40'h0, lagAccum);
        testName = "sparseEnable";
        repeat (200) begin
            @(posedge clk);
            driveRandomErrors();
            drawBits(3, bits);
            clkEn <= (bits[2:0] == 3'd0);
            drawBits(5, bits);
            clearAccum <= (bits[4:0] == 5'd0);
            drawBits(1, bits);
            freqAcquired <= bits[0];
            drawBits(15, bits);
            phaseLagExp <= bits[4:0];
            freqLagExp  <= bits[9:5];
            leadExp     <= bits[14:10];
        end
    endtask

    // Phase step follows the loop output of the previous enable
    task automatic advanceNco;
        logic [31:0] bits;
        logic [31:0] prevPhase;
        logic [39:0] prevLoop;
        testName = "ncoWrap";
        drawBits(32, bits);
        @(posedge clk);
        clkEn        <= 1'b1;
        clearAccum   <= 1'b0;
        freqAcquired <= 1'b1;
        phaseLagExp  <= 5'd5;
        leadExp      <= 5'd7;
        centerFreq   <= {1'b1, bits[30:0]};
        @(negedge clk);
        prevPhase = mPhase;
        prevLoop  = mLoopOut;
        repeat (40) begin
            @(posedge clk);
            driveRandomErrors();
            @(negedge clk);
            prevPhase = prevPhase + centerFreq + prevLoop[39:8];
            checkWord("ncoStep", {8'h00, prevPhase}, {8'h00, ncoPhase});
            prevLoop = mLoopOut;
        end
    endtask

    initial begin : watchdog
        repeat (runLimit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", runLimit);
        reportCounts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        lfsrState     = 32'h2c43_2f31;
        testName      = "reset";
        checking      = 1'b0;
        checkCount    = 0;
        valueErrors   = 0;
        timeoutErrors = 0;
        reset         = 1'b1;
        clkEn         = 1'b0;
        clearAccum    = 1'b0;
        freqAcquired  = 1'b0;
        phaseError    = '0;
        freqError     = '0;
        phaseLagExp   = '0;
        freqLagExp    = '0;
        leadExp       = '0;
        upperLimit    = '0;
        lowerLimit    = '0;
        centerFreq    = '0;
        repeat (4) @(posedge clk);
        reset    <= 1'b0;
        checking <= 1'b1;
        idleAfterReset();
        scaleAllCodes();
        switchMode();
        saturateBothWays();
        clearAndSparse();
        advanceNco();
        @(negedge clk);
        reportCounts();
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+hw
hw/loopGainPkg.sv
hw/loopControlPkg.sv
hw/loopConfigIf.sv
hw/lagGain.sv
hw/leadGain.sv
hw/carrierNco.sv
hw/carrierLoopFilter.sv
testbench/carrierLoopFilterTb.sv
